// ==== sim.f ====
rtl/csr_pkg.sv
rtl/csr_access_decode.sv
rtl/csr_exception_regs.sv
rtl/csr_timer.sv
rtl/csr_scratch_regs.sv
rtl/csr_read_mux.sv
rtl/csr_file.sv
bench/csr_file_asserts.sv
bench/tb_csr_file.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_access_decode.sv
  - rtl/csr_exception_regs.sv
  - rtl/csr_timer.sv
  - rtl/csr_scratch_regs.sv
  - rtl/csr_read_mux.sv
  - rtl/csr_file.sv
  - target: simulation
    files:
      - bench/csr_file_asserts.sv
      - bench/tb_csr_file.sv

// ==== bench/tb_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_file import csr_pkg::*; ();

    logic                    clk;
    logic                    reset;
    csr_addr_e               csr_num;
    logic                    csr_re;
    logic                    csr_we;
    logic [XLEN-1:0]         csr_wmask;
    logic [XLEN-1:0]         csr_wvalue;
    logic [XLEN-1:0]         csr_rvalue;
    logic                    wb_ex;
    ecode_e                  wb_ecode;
    logic [8:0]              wb_esubcode;
    logic [XLEN-1:0]         wb_pc;
    logic [XLEN-1:0]         wb_vaddr;
    logic                    ertn_flush;
    logic [HW_INT_WIDTH-1:0] hw_int;
    logic                    ipi_int;
    logic                    has_int;
    logic [XLEN-1:0]         era_pc;
    logic [XLEN-1:0]         eentry_data;

    logic [15:0] lfsr_state;
    int          timeout_count;
    int          fail_total;
    ecode_e      codes [6] = '{ECODE_ADE, ECODE_SYS, ECODE_ALE, ECODE_BRK, ECODE_INE, ECODE_INT};

    csr_file #(.SAVE_COUNT(4)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Address and read enable stay on the register for the cycle after the write
    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        @(posedge clk);
        csr_num    <= csr_addr_e'(num);
        csr_re     <= 1'b1;
        csr_we     <= 1'b1;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic read_csr(input logic [13:0] num);
        @(posedge clk);
        csr_num <= csr_addr_e'(num);
        csr_re  <= 1'b1;
        @(posedge clk);
    endtask

    task automatic raise_exception(input ecode_e code);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= code;
        wb_esubcode <= 9'(random_bits(9));
        wb_pc       <= random_bits(32);
        wb_vaddr    <= random_bits(32);
        @(posedge clk);
        wb_ex <= 1'b0;
    endtask

    task automatic return_from_exception();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    task automatic wait_for_int(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!has_int && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!has_int) begin
            $display("timeout: has_int did not rise within %0d cycles", limit);
            timeout_count++;
        end
    endtask

    initial begin
        lfsr_state    = 16'd16091;
        timeout_count = 0;
        reset         = 1'b1;
        csr_num       = CSR_CRMD;
        csr_re        = 1'b0;
        csr_we        = 1'b0;
        csr_wmask     = '0;
        csr_wvalue    = '0;
        wb_ex         = 1'b0;
        wb_ecode      = ECODE_INT;
        wb_esubcode   = '0;
        wb_pc         = '0;
        wb_vaddr      = '0;
        ertn_flush    = 1'b0;
        hw_int        = '0;
        ipi_int       = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Second pass merges into nonzero old values
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 4; i++) begin
                write_csr(14'h30 + 14'(i), random_bits(32), random_bits(32));
            end
            write_csr(CSR_TID, random_bits(32), random_bits(32));
            write_csr(CSR_EENTRY, random_bits(32), random_bits(32));
            write_csr(CSR_ECFG, random_bits(32), random_bits(32));
        end
        write_csr(14'h2a, '1, '1);
        read_csr(14'h34);
        read_csr(14'h02);
        read_csr(14'h43);
        read_csr(14'h3fff);

        for (int i = 0; i < 6; i++) begin
            write_csr(CSR_CRMD, 32'h7, random_bits(3));
            raise_exception(codes[i]);
            if (i % 2 == 1) begin
                write_csr(CSR_PRMD, 32'h7, random_bits(3));
            end
            return_from_exception();
        end

        write_csr(CSR_ECFG, '1, 32'h1fff);
        for (int i = 0; i < 48; i++) begin
            @(posedge clk);
            hw_int  <= 8'(random_bits(8));
            ipi_int <= 1'(random_bits(1));
            if (i % 8 == 0) begin
                write_csr(CSR_ESTAT, 32'h3, random_bits(2));
            end
            if (i % 8 == 4) begin
                write_csr(CSR_CRMD, 32'h4, random_bits(3));
            end
        end

        // Only the timer may raise has_int from here on
        @(posedge clk);
        hw_int  <= '0;
        ipi_int <= 1'b0;
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        write_csr(CSR_ECFG, '1, 32'h800);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        write_csr(CSR_TCFG, '1, 32'h0000_000d);
        wait_for_int(64);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        write_csr(CSR_TCFG, '1, 32'h0000_000b);
        wait_for_int(64);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        wait_for_int(64);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        write_csr(CSR_TCFG, '1, 32'h0);
        repeat (4) @(posedge clk);

        fail_total = uut.checks.fail_count;
        $display("assertion failures: %0d, timeouts: %0d", fail_total, timeout_count);
        if (fail_total == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/csr_file_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file_asserts import csr_pkg::*; #(
    parameter int SAVE_COUNT = 4
) (
    input logic                    clk,
    input logic                    reset,
    input csr_addr_e               csr_num,
    input logic                    csr_re,
    input logic                    csr_we,
    input logic [XLEN-1:0]         csr_wmask,
    input logic [XLEN-1:0]         csr_wvalue,
    input logic [XLEN-1:0]         csr_rvalue,
    input logic                    wb_ex,
    input ecode_e                  wb_ecode,
    input logic [8:0]              wb_esubcode,
    input logic [XLEN-1:0]         wb_pc,
    input logic [XLEN-1:0]         wb_vaddr,
    input logic                    ertn_flush,
    input logic [HW_INT_WIDTH-1:0] hw_int,
    input logic                    ipi_int,
    input logic                    has_int,
    input logic [XLEN-1:0]         era_pc,
    input logic [XLEN-1:0]         eentry_data,
    input logic [XLEN-1:0]         crmd_data,
    input logic [XLEN-1:0]         prmd_data,
    input logic [XLEN-1:0]         ecfg_data,
    input logic [XLEN-1:0]         estat_data,
    input logic [XLEN-1:0]         badv_data,
    input logic [XLEN-1:0]         tcfg_data,
    input logic                    timer_int
);

    int fail_count = 0;

    logic [XLEN-1:0] merged;
    logic [XLEN-1:0] write_exp;
    logic            write_seen;
    logic [XLEN-1:0] tcfg_merged;
    logic [12:0]     is_exp;
    logic            wr_chk_q;
    logic [13:0]     wr_num_q;
    logic [XLEN-1:0] wr_exp_q;
    logic            ex_q;
    logic            ertn_q;
    logic            clear_q;
    logic            timer_q;
    logic [7:0]      hw_q;
    logic            ipi_q;
    logic [2:0]      mode_q;
    logic [2:0]      prmd_q;
    logic [XLEN-1:0] pc_q;
    logic [5:0]      code_q;
    logic [8:0]      sub_q;
    logic [XLEN-1:0] badv_exp_q;
    logic            tmr_armed;
    logic            tmr_periodic;
    logic [XLEN-1:0] tmr_left;
    logic [XLEN-1:0] tmr_reload;
    logic            fire_q;

    function automatic logic in_save(input logic [13:0] num);
        return (num >= 14'h30) && (num < 14'h30 + SAVE_COUNT);
    endfunction

    function automatic logic is_known(input logic [13:0] num);
        return in_save(num) || (num inside {14'h00, 14'h01, 14'h04, 14'h05, 14'h06,
            14'h07, 14'h0c, 14'h40, 14'h41, 14'h42, 14'h44});
    endfunction

    // Masked bits from the write, the rest from the old read
    assign merged      = (csr_wmask & csr_wvalue) | (~csr_wmask & csr_rvalue);
    assign tcfg_merged = (csr_wmask & csr_wvalue) | (~csr_wmask & tcfg_data);
    assign is_exp      = {ipi_q, timer_int, 1'b0, hw_q, estat_data[1:0]};

    always_comb begin
        write_exp  = merged;
        write_seen = csr_we && csr_re;
        if (csr_num == CSR_EENTRY) begin
            write_exp = merged & 32'hffff_ffc0;
        end else if (csr_num == CSR_ECFG) begin
            write_exp = merged & 32'h0000_1bff;
        end else if (csr_num != CSR_TID && !in_save(csr_num)) begin
            write_seen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_chk_q <= 1'b0;
            ex_q     <= 1'b0;
            ertn_q   <= 1'b0;
            clear_q  <= 1'b0;
            timer_q  <= 1'b0;
            hw_q     <= '0;
            ipi_q    <= 1'b0;
        end else begin
            wr_chk_q <= write_seen;
            ex_q     <= wb_ex;
            ertn_q   <= ertn_flush && !wb_ex;
            clear_q  <= csr_we && csr_num == CSR_TICLR && csr_wmask[0] && csr_wvalue[0];
            timer_q  <= timer_int;
            hw_q     <= hw_int;
            ipi_q    <= ipi_int;
        end
    end

    always_ff @(posedge clk) begin
        wr_num_q   <= csr_num;
        wr_exp_q   <= write_exp;
        mode_q     <= crmd_data[2:0];
        prmd_q     <= prmd_data[2:0];
        pc_q       <= wb_pc;
        code_q     <= wb_ecode;
        sub_q      <= wb_esubcode;
        badv_exp_q <= (wb_ecode == ECODE_ADE || wb_ecode == ECODE_ALE) ? wb_vaddr : badv_data;
    end

    // Reference countdown that fires 4*INITVAL+1 edges after the TCFG write
    always_ff @(posedge clk) begin
        if (reset) begin
            tmr_armed    <= 1'b0;
            tmr_periodic <= 1'b0;
            tmr_left     <= '0;
            tmr_reload   <= '0;
            fire_q       <= 1'b0;
        end else begin
            fire_q <= 1'b0;
            if (csr_we && csr_num == CSR_TCFG) begin
                tmr_armed    <= tcfg_merged[0];
                tmr_periodic <= tcfg_merged[1];
                tmr_left     <= {tcfg_merged[31:2], 2'b00};
                tmr_reload   <= {tcfg_merged[31:2], 2'b00};
            end else if (tmr_armed) begin
                if (tmr_left == '0) begin
                    fire_q    <= 1'b1;
                    tmr_armed <= tmr_periodic;
                    tmr_left  <= tmr_reload;
                end else begin
                    tmr_left <= tmr_left - 1'b1;
                end
            end
        end
    end

    write_merge: assert property (@(posedge clk) disable iff (reset)
        wr_chk_q && csr_re && csr_num == wr_num_q |-> csr_rvalue == wr_exp_q)
    else begin
        $error("error csr_rvalue 0x%h expected 0x%h", $sampled(csr_rvalue),
            $sampled(wr_exp_q));
        fail_count++;
    end

    eentry_port: assert property (@(posedge clk) disable iff (reset)
        wr_chk_q && wr_num_q == CSR_EENTRY |-> eentry_data == wr_exp_q)
    else begin
        $error("error eentry_data 0x%h expected 0x%h", $sampled(eentry_data),
            $sampled(wr_exp_q));
        fail_count++;
    end

    unknown_read: assert property (@(posedge clk) disable iff (reset)
        !csr_re || !is_known(csr_num) |-> csr_rvalue == '0)
    else begin
        $error("error csr_rvalue 0x%h expected 0x0 for csr_num 0x%h",
            $sampled(csr_rvalue), $sampled(csr_num));
        fail_count++;
    end

    entry_mode: assert property (@(posedge clk) disable iff (reset)
        ex_q |-> crmd_data[2:0] == 3'b0 && prmd_data[2:0] == mode_q)
    else begin
        $error("error crmd_data 0x%h prmd_data 0x%h expected prmd mode 0x%h",
            $sampled(crmd_data), $sampled(prmd_data), $sampled(mode_q));
        fail_count++;
    end

    entry_capture: assert property (@(posedge clk) disable iff (reset)
        ex_q |-> era_pc == pc_q && estat_data[30:16] == {sub_q, code_q}
            && badv_data == badv_exp_q)
    else begin
        $error("error era_pc 0x%h estat_data 0x%h badv_data 0x%h expected 0x%h 0x%h 0x%h",
            $sampled(era_pc), $sampled(estat_data), $sampled(badv_data),
            $sampled(pc_q), $sampled({sub_q, code_q}), $sampled(badv_exp_q));
        fail_count++;
    end

    return_mode: assert property (@(posedge clk) disable iff (reset)
        ertn_q |-> crmd_data[2:0] == prmd_q)
    else begin
        $error("error crmd_data 0x%h expected mode 0x%h", $sampled(crmd_data),
            $sampled(prmd_q));
        fail_count++;
    end

    // External lines show up one cycle late
    status_lines: assert property (@(posedge clk) disable iff (reset)
        estat_data[9:2] == hw_q && estat_data[12] == ipi_q)
    else begin
        $error("error estat_data 0x%h expected hw 0x%h ipi 0x%h",
            $sampled(estat_data), $sampled(hw_q), $sampled(ipi_q));
        fail_count++;
    end

    int_rule: assert property (@(posedge clk) disable iff (reset)
        has_int == ((|(is_exp & ecfg_data[12:0])) && crmd_data[2]))
    else begin
        $error("error has_int 0x%h estat_data 0x%h ecfg_data 0x%h crmd_data 0x%h",
            $sampled(has_int), $sampled(estat_data), $sampled(ecfg_data),
            $sampled(crmd_data));
        fail_count++;
    end

    timer_fire: assert property (@(posedge clk) disable iff (reset)
        fire_q |-> timer_int)
    else begin
        $error("timer interrupt did not set on its timeout edge");
        fail_count++;
    end

    timer_rise: assert property (@(posedge clk) disable iff (reset)
        timer_int && !timer_q |-> fire_q)
    else begin
        $error("timer interrupt set on an edge that was not a timeout");
        fail_count++;
    end

    timer_clear: assert property (@(posedge clk) disable iff (reset)
        clear_q && !fire_q |-> !timer_int)
    else begin
        $error("timer interrupt still set after a TICLR write");
        fail_count++;
    end

endmodule

bind csr_file csr_file_asserts #(.SAVE_COUNT(SAVE_COUNT)) checks (.*);

`default_nettype wire

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_addr_e               csr_num,
    input  logic                    csr_re,
    input  logic                    csr_we,
    input  logic [XLEN-1:0]         csr_wmask,
    input  logic [XLEN-1:0]         csr_wvalue,
    output logic [XLEN-1:0]         csr_rvalue,
    input  logic                    wb_ex,
    input  ecode_e                  wb_ecode,
    input  logic [8:0]              wb_esubcode,
    input  logic [XLEN-1:0]         wb_pc,
    input  logic [XLEN-1:0]         wb_vaddr,
    input  logic                    ertn_flush,
    input  logic [HW_INT_WIDTH-1:0] hw_int,
    input  logic                    ipi_int,
    output logic                    has_int,
    output logic [XLEN-1:0]         era_pc,
    output logic [XLEN-1:0]         eentry_data
);

    csr_sel_t              wr_sel;
    csr_sel_t              rd_sel;
    logic [SAVE_COUNT-1:0] save_wr_sel;
    logic [SAVE_COUNT-1:0] save_rd_sel;
    logic [XLEN-1:0]       crmd_data;
    logic [XLEN-1:0]       prmd_data;
    logic [XLEN-1:0]       ecfg_data;
    logic [XLEN-1:0]       estat_data;
    logic [XLEN-1:0]       badv_data;
    logic [XLEN-1:0]       tid_data;
    logic [XLEN-1:0]       tcfg_data;
    logic [XLEN-1:0]       tval_data;
    logic [XLEN-1:0]       ticlr_data;
    logic [XLEN-1:0]       save_data [SAVE_COUNT];
    logic                  timer_int;

    csr_access_decode #(.SAVE_COUNT(SAVE_COUNT)) u_decode (
        .csr_num(csr_num), .csr_we(csr_we), .csr_re(csr_re),
        .wr_sel(wr_sel), .rd_sel(rd_sel),
        .save_wr_sel(save_wr_sel), .save_rd_sel(save_rd_sel)
    );

    csr_exception_regs u_exception (
        .clk(clk), .reset(reset), .wr_sel(wr_sel),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_ecode(wb_ecode),
        .wb_esubcode(wb_esubcode), .wb_pc(wb_pc), .wb_vaddr(wb_vaddr),
        .hw_int(hw_int), .ipi_int(ipi_int), .timer_int(timer_int),
        .crmd_data(crmd_data), .prmd_data(prmd_data), .ecfg_data(ecfg_data),
        .estat_data(estat_data), .era_data(era_pc), .badv_data(badv_data),
        .eentry_data(eentry_data), .has_int(has_int)
    );

    csr_timer u_timer (
        .clk(clk), .reset(reset),
        .tcfg_we(wr_sel[SEL_TCFG]), .ticlr_we(wr_sel[SEL_TICLR]),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .tcfg_data(tcfg_data), .tval_data(tval_data), .ticlr_data(ticlr_data),
        .timer_int(timer_int)
    );

    csr_scratch_regs #(.SAVE_COUNT(SAVE_COUNT)) u_scratch (
        .clk(clk), .reset(reset), .save_wr_sel(save_wr_sel), .tid_we(wr_sel[SEL_TID]),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .save_data(save_data), .tid_data(tid_data)
    );

    csr_read_mux #(.SAVE_COUNT(SAVE_COUNT)) u_read_mux (
        .csr_re(csr_re), .rd_sel(rd_sel), .save_rd_sel(save_rd_sel),
        .crmd_data(crmd_data), .prmd_data(prmd_data), .ecfg_data(ecfg_data),
        .estat_data(estat_data), .era_data(era_pc), .badv_data(badv_data),
        .eentry_data(eentry_data), .tid_data(tid_data), .tcfg_data(tcfg_data),
        .tval_data(tval_data), .ticlr_data(ticlr_data), .save_data(save_data),
        .csr_rvalue(csr_rvalue)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux import csr_pkg::*; #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                  csr_re,
    input  csr_sel_t              rd_sel,
    input  logic [SAVE_COUNT-1:0] save_rd_sel,
    input  logic [XLEN-1:0]       crmd_data,
    input  logic [XLEN-1:0]       prmd_data,
    input  logic [XLEN-1:0]       ecfg_data,
    input  logic [XLEN-1:0]       estat_data,
    input  logic [XLEN-1:0]       era_data,
    input  logic [XLEN-1:0]       badv_data,
    input  logic [XLEN-1:0]       eentry_data,
    input  logic [XLEN-1:0]       tid_data,
    input  logic [XLEN-1:0]       tcfg_data,
    input  logic [XLEN-1:0]       tval_data,
    input  logic [XLEN-1:0]       ticlr_data,
    input  logic [XLEN-1:0]       save_data [SAVE_COUNT],
    output logic [XLEN-1:0]       csr_rvalue
);

    logic [XLEN-1:0] words [SEL_COUNT];
    logic [XLEN-1:0] save_word;
    logic [XLEN-1:0] selected;

    always_comb begin
        save_word = '0;
        for (int i = 0; i < SAVE_COUNT; i++) begin
            save_word |= {XLEN{save_rd_sel[i]}} & save_data[i];
        end
    end

    assign words[SEL_CRMD]   = crmd_data;
    assign words[SEL_PRMD]   = prmd_data;
    assign words[SEL_ECFG]   = ecfg_data;
    assign words[SEL_ESTAT]  = estat_data;
    assign words[SEL_ERA]    = era_data;
    assign words[SEL_BADV]   = badv_data;
    assign words[SEL_EENTRY] = eentry_data;
    assign words[SEL_SAVE]   = save_word;
    assign words[SEL_TID]    = tid_data;
    assign words[SEL_TCFG]   = tcfg_data;
    assign words[SEL_TVAL]   = tval_data;
    assign words[SEL_TICLR]  = ticlr_data;

    // AND-OR over the one-hot select
    always_comb begin
        selected = '0;
        for (int i = 0; i < SEL_COUNT; i++) begin
            selected |= {XLEN{rd_sel[i]}} & words[i];
        end
    end

    assign csr_rvalue = csr_re ? selected : '0;

endmodule

`default_nettype wire

// ==== rtl/csr_scratch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_scratch_regs import csr_pkg::*; #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [SAVE_COUNT-1:0] save_wr_sel,
    input  logic                  tid_we,
    input  logic [XLEN-1:0]       csr_wmask,
    input  logic [XLEN-1:0]       csr_wvalue,
    output logic [XLEN-1:0]       save_data [SAVE_COUNT],
    output logic [XLEN-1:0]       tid_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SAVE_COUNT; i++) begin
                save_data[i] <= '0;
            end
        end else begin
            for (int i = 0; i < SAVE_COUNT; i++) begin
                if (save_wr_sel[i]) begin
                    save_data[i] <= masked_merge(save_data[i], csr_wmask, csr_wvalue);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_data <= '0;
        end else if (tid_we) begin
            tid_data <= masked_merge(tid_data, csr_wmask, csr_wvalue);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            tcfg_we,
    input  logic            ticlr_we,
    input  logic [XLEN-1:0] csr_wmask,
    input  logic [XLEN-1:0] csr_wvalue,
    output logic [XLEN-1:0] tcfg_data,
    output logic [XLEN-1:0] tval_data,
    output logic [XLEN-1:0] ticlr_data,
    output logic            timer_int
);

    logic            tcfg_en;
    logic            tcfg_periodic;
    logic [29:0]     tcfg_initval;
    logic [XLEN-1:0] tcfg_next;
    logic [XLEN-1:0] timer_cnt;
    logic            timeout;
    logic            clear_req;

    assign tcfg_next = masked_merge(tcfg_data, csr_wmask, csr_wvalue);
    assign timeout   = tcfg_en && (timer_cnt == '0);
    assign clear_req = ticlr_we && csr_wmask[0] && csr_wvalue[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= 30'b0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_next[0];
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    // All ones means stopped; one-shot wraps there after zero
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (tcfg_we && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[31:2], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timeout && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Timeout beats a clear on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (timeout) begin
            timer_int <= 1'b1;
        end else if (clear_req) begin
            timer_int <= 1'b0;
        end
    end

    assign tcfg_data  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tval_data  = timer_cnt;
    assign ticlr_data = '0;

endmodule

`default_nettype wire

// ==== rtl/csr_exception_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_exception_regs import csr_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_sel_t                wr_sel,
    input  logic [XLEN-1:0]         csr_wmask,
    input  logic [XLEN-1:0]         csr_wvalue,
    input  logic                    wb_ex,
    input  logic                    ertn_flush,
    input  ecode_e                  wb_ecode,
    input  logic [8:0]              wb_esubcode,
    input  logic [XLEN-1:0]         wb_pc,
    input  logic [XLEN-1:0]         wb_vaddr,
    input  logic [HW_INT_WIDTH-1:0] hw_int,
    input  logic                    ipi_int,
    input  logic                    timer_int,
    output logic [XLEN-1:0]         crmd_data,
    output logic [XLEN-1:0]         prmd_data,
    output logic [XLEN-1:0]         ecfg_data,
    output logic [XLEN-1:0]         estat_data,
    output logic [XLEN-1:0]         era_data,
    output logic [XLEN-1:0]         badv_data,
    output logic [XLEN-1:0]         eentry_data,
    output logic                    has_int
);

    logic [1:0]              crmd_plv;
    logic                    crmd_ie;
    logic                    crmd_da;
    logic                    crmd_pg;
    logic [1:0]              crmd_datf;
    logic [1:0]              crmd_datm;
    logic [1:0]              prmd_pplv;
    logic                    prmd_pie;
    logic [INT_WIDTH-1:0]    ecfg_lie;
    logic [1:0]              estat_sw_is;
    logic [HW_INT_WIDTH-1:0] estat_hw_is;
    logic                    estat_ipi_is;
    logic [INT_WIDTH-1:0]    estat_is;
    logic [5:0]              estat_ecode;
    logic [8:0]              estat_esubcode;
    logic [XLEN-1:0]         era;
    logic [XLEN-1:0]         badv;
    logic [25:0]             eentry_va;
    logic [XLEN-1:0]         crmd_wr;
    logic [XLEN-1:0]         prmd_wr;
    logic [XLEN-1:0]         ecfg_wr;
    logic [XLEN-1:0]         estat_wr;
    logic                    addr_err;

    assign crmd_wr  = masked_merge(crmd_data, csr_wmask, csr_wvalue);
    assign prmd_wr  = masked_merge(prmd_data, csr_wmask, csr_wvalue);
    assign ecfg_wr  = masked_merge(ecfg_data, csr_wmask, csr_wvalue);
    assign estat_wr = masked_merge(estat_data, csr_wmask, csr_wvalue);
    assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    // PLV and IE: exception entry first, then return, then software
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_sel[SEL_CRMD]) begin
            crmd_plv <= crmd_wr[1:0];
            crmd_ie  <= crmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'b0;
            crmd_datm <= 2'b0;
        end else if (wr_sel[SEL_CRMD]) begin
            crmd_da   <= crmd_wr[3];
            crmd_pg   <= crmd_wr[4];
            crmd_datf <= crmd_wr[6:5];
            crmd_datm <= crmd_wr[8:7];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_sel[SEL_PRMD]) begin
            prmd_pplv <= prmd_wr[1:0];
            prmd_pie  <= prmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (wr_sel[SEL_ECFG]) begin
            ecfg_lie <= ecfg_wr[INT_WIDTH-1:0] & LIE_WRITABLE;
        end
    end

    // External lines land in ESTAT one cycle after they are sampled
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_sw_is    <= 2'b0;
            estat_hw_is    <= '0;
            estat_ipi_is   <= 1'b0;
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
        end else begin
            estat_hw_is  <= hw_int;
            estat_ipi_is <= ipi_int;
            if (wr_sel[SEL_ESTAT]) begin
                estat_sw_is <= estat_wr[1:0];
            end
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era       <= '0;
            badv      <= '0;
            eentry_va <= 26'b0;
        end else begin
            if (wb_ex) begin
                era <= wb_pc;
            end else if (wr_sel[SEL_ERA]) begin
                era <= masked_merge(era, csr_wmask, csr_wvalue);
            end
            if (wb_ex && addr_err) begin
                badv <= wb_vaddr;
            end else if (wr_sel[SEL_BADV]) begin
                badv <= masked_merge(badv, csr_wmask, csr_wvalue);
            end
            if (wr_sel[SEL_EENTRY]) begin
                eentry_va <= csr_wmask[31:6] & csr_wvalue[31:6] | ~csr_wmask[31:6] & eentry_va;
            end
        end
    end

    // Timer bit follows the sticky flag held in the timer block
    assign estat_is = {estat_ipi_is, timer_int, 1'b0, estat_hw_is, estat_sw_is};

    assign crmd_data   = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd_data   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_data   = {{(XLEN - INT_WIDTH){1'b0}}, ecfg_lie};
    assign estat_data  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign era_data    = era;
    assign badv_data   = badv;
    assign eentry_data = {eentry_va, 6'b0};

    assign has_int = (|(estat_is & ecfg_lie)) && crmd_ie;

endmodule

`default_nettype wire

// ==== rtl/csr_access_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_access_decode import csr_pkg::*; #(
    parameter int SAVE_COUNT = 4
) (
    input  csr_addr_e              csr_num,
    input  logic                   csr_we,
    input  logic                   csr_re,
    output csr_sel_t               wr_sel,
    output csr_sel_t               rd_sel,
    output logic [SAVE_COUNT-1:0]  save_wr_sel,
    output logic [SAVE_COUNT-1:0]  save_rd_sel
);

    csr_sel_t              hit;
    logic [SAVE_COUNT-1:0] save_hit;

    always_comb begin
        hit = '0;
        for (int i = 0; i < SAVE_COUNT; i++) begin
            save_hit[i] = (csr_num == 14'(CSR_SAVE0) + 14'(i));
        end
        case (csr_num)
            CSR_CRMD:   hit[SEL_CRMD] = 1'b1;
            CSR_PRMD:   hit[SEL_PRMD] = 1'b1;
            CSR_ECFG:   hit[SEL_ECFG] = 1'b1;
            CSR_ESTAT:  hit[SEL_ESTAT] = 1'b1;
            CSR_ERA:    hit[SEL_ERA] = 1'b1;
            CSR_BADV:   hit[SEL_BADV] = 1'b1;
            CSR_EENTRY: hit[SEL_EENTRY] = 1'b1;
            CSR_TID:    hit[SEL_TID] = 1'b1;
            CSR_TCFG:   hit[SEL_TCFG] = 1'b1;
            CSR_TVAL:   hit[SEL_TVAL] = 1'b1;
            CSR_TICLR:  hit[SEL_TICLR] = 1'b1;
            default:    hit = '0;
        endcase
        hit[SEL_SAVE] = |save_hit;
    end

    // Unknown addresses leave every select low
    assign rd_sel      = csr_re ? hit : '0;
    assign save_rd_sel = csr_re ? save_hit : '0;
    assign wr_sel      = csr_we ? hit : '0;
    assign save_wr_sel = csr_we ? save_hit : '0;

endmodule

`default_nettype wire

// ==== rtl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;
    localparam int INT_WIDTH = 13;
    localparam int HW_INT_WIDTH = 8;
    localparam logic [INT_WIDTH-1:0] LIE_WRITABLE = 13'h1bff;
    localparam int TIMER_INT_BIT = 11;
    localparam int IPI_BIT = 12;

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h00,
        CSR_PRMD   = 14'h01,
        CSR_ECFG   = 14'h04,
        CSR_ESTAT  = 14'h05,
        CSR_ERA    = 14'h06,
        CSR_BADV   = 14'h07,
        CSR_EENTRY = 14'h0c,
        CSR_SAVE0  = 14'h30,
        CSR_TID    = 14'h40,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_addr_e;

    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    // Bit positions in the one-hot select, SEL_SAVE covers the whole scratch range
    typedef enum int {
        SEL_CRMD,
        SEL_PRMD,
        SEL_ECFG,
        SEL_ESTAT,
        SEL_ERA,
        SEL_BADV,
        SEL_EENTRY,
        SEL_SAVE,
        SEL_TID,
        SEL_TCFG,
        SEL_TVAL,
        SEL_TICLR
    } csr_sel_e;

    localparam int SEL_COUNT = 12;

    typedef logic [SEL_COUNT-1:0] csr_sel_t;

    function automatic logic [XLEN-1:0] masked_merge(
        input logic [XLEN-1:0] old_value,
        input logic [XLEN-1:0] mask,
        input logic [XLEN-1:0] value
    );
        return (mask & value) | (~mask & old_value);
    endfunction

endpackage

`default_nettype wire
